//--- compile.f
src/trap_pkg.sv
src/trap_cause_sel.sv
src/trap_csr_regs.sv
src/trap_ctrl_fsm.sv
src/retire_counter.sv
src/trap_unit.sv
sim/tb_trap_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_trap_unit \
  -f compile.f -o tb_trap_unit \
  && ./obj_dir/tb_trap_unit > sim.log 2>&1
grep -q "=== PASS ===" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/tb_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trap_unit;

  import trap_pkg::*;

  localparam addr_t MTVEC        = 32'h0000_0200;
  localparam int    RAND_CYCLES  = 3000;
  localparam int    STEP_ROUNDS  = 6;
  localparam int    HALT_CYCLES  = 6;
  localparam int    WAIT_TIMEOUT = 64;

  logic      clk = 1'b0;
  logic      rst_ni;
  wb_instr_t wb_i;
  irq_vec_t  irq_i;
  csr_wr_t   csr_wr_i;
  logic      debug_step_i;
  logic      debug_resume_i;
  logic      trap_o;
  logic      mret_o;
  addr_t     redirect_pc_o;
  logic      stall_o;
  logic      debug_mode_o;
  addr_t     mepc_o;
  mcause_t   mcause_o;
  logic      mstatus_mie_o;
  count_t    minstret_o;

  // Levels that the directed step phase hands to the driver
  logic step_lvl;
  logic resume_req;
  int   seed = 32'h655efa76;

  // Reference state that is advanced once per rising edge
  ctrl_state_e m_state;
  irq_vec_t    m_mie;
  logic        m_gie;
  logic        m_mpie;
  addr_t       m_mepc;
  mcause_t     m_mcause;
  count_t      m_minstret;
  logic        m_mret_q;

  always #20 clk = ~clk;

  trap_unit #(
    .MTVEC_BASE (MTVEC)
  ) dut (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .wb_i           (wb_i),
    .irq_i          (irq_i),
    .csr_wr_i       (csr_wr_i),
    .debug_step_i   (debug_step_i),
    .debug_resume_i (debug_resume_i),
    .trap_o         (trap_o),
    .mret_o         (mret_o),
    .redirect_pc_o  (redirect_pc_o),
    .stall_o        (stall_o),
    .debug_mode_o   (debug_mode_o),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause_o),
    .mstatus_mie_o  (mstatus_mie_o),
    .minstret_o     (minstret_o)
  );

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic addr_check(addr_t got, addr_t exp, string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic cause_check(mcause_t got, mcause_t exp, string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic count_check(count_t got, count_t exp, string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic bit_check(logic got, logic exp, string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Lowest pending and enabled line wins
  function automatic exc_code_t lowest_irq(irq_vec_t lines);
    for (int i = 0; i < 16; i++) begin
      if (lines[i]) return exc_code_t'(i);
    end
    return '0;
  endfunction

  // Zero means the instruction carries no fault
  function automatic exc_code_t fault_code(wb_instr_t w);
    if (w.mpu_err) return EXC_INSTR_FAULT;
    if (w.bus_err) return EXC_INSTR_BUS_FAULT;
    if (w.illegal) return EXC_ILLEGAL_INSN;
    if (w.ecall) return EXC_ECALL_MMODE;
    if (w.ebrk) return EXC_BREAKPOINT;
    return '0;
  endfunction

  task automatic reset_model();
    m_state    = ST_RUN;
    m_mie      = '0;
    m_gie      = 1'b0;
    m_mpie     = 1'b0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_minstret = '0;
    m_mret_q   = 1'b0;
  endtask

  task automatic advance_model();
    irq_vec_t  pend_en;
    mcause_t   cause;
    exc_code_t fcode;
    logic      fire;
    logic      take;
    logic      retire;
    logic      step_end;
    // Writeback slots seen outside RUN are dropped entirely
    fire    = wb_i.valid && (m_state == ST_RUN);
    pend_en = irq_i & m_mie;
    fcode   = fault_code(wb_i);
    cause   = '0;
    take    = 1'b0;
    if (fire && m_gie && (pend_en != '0)) begin
      take                 = 1'b1;
      cause.interrupt      = 1'b1;
      cause.exception_code = lowest_irq(pend_en);
    end else if (fire && (fcode != '0)) begin
      take                 = 1'b1;
      cause.exception_code = fcode;
    end
    retire   = fire && !take;
    // The step level stays high through any trap, so the first real retirement ends it
    step_end = retire && debug_step_i;
    // Trap entry beats MRET, which beats a software write to mstatus
    if (take) begin
      m_mpie   = m_gie;
      m_gie    = 1'b0;
      m_mepc   = wb_i.pc;
      m_mcause = cause;
    end else if (retire && wb_i.mret) begin
      m_gie  = m_mpie;
      m_mpie = 1'b1;
    end else if (csr_wr_i.en && (csr_wr_i.sel == CSR_MSTATUS)) begin
      m_gie = csr_wr_i.data[3];
    end
    if (!take && csr_wr_i.en && (csr_wr_i.sel == CSR_MEPC)) begin
      m_mepc = csr_wr_i.data;
    end
    if (csr_wr_i.en && (csr_wr_i.sel == CSR_MIE)) begin
      m_mie = csr_wr_i.data[15:0];
    end
    if (retire) begin
      m_minstret = m_minstret + 1;
    end
    m_mret_q = retire && wb_i.mret;
    case (m_state)
      ST_RUN: begin
        if (take) begin
          m_state = ST_TRAP;
        end else if (step_end) begin
          m_state = ST_HALT;
        end
      end
      ST_TRAP: m_state = ST_RUN;
      default: begin
        if (debug_resume_i) begin
          m_state = ST_RUN;
        end
      end
    endcase
  endtask

  task automatic compare_all();
    bit_check(trap_o, m_state == ST_TRAP, "trap_o");
    bit_check(stall_o, m_state != ST_RUN, "stall_o");
    bit_check(debug_mode_o, m_state == ST_HALT, "debug_mode_o");
    bit_check(mret_o, m_mret_q, "mret_o");
    bit_check(mstatus_mie_o, m_gie, "mstatus_mie_o");
    // The redirect target matters on trap entry and on the MRET pulse
    if (m_state == ST_TRAP) begin
      addr_check(redirect_pc_o, MTVEC, "redirect_pc_o on trap entry");
    end else if (m_mret_q) begin
      addr_check(redirect_pc_o, m_mepc, "redirect_pc_o on MRET");
    end
    addr_check(mepc_o, m_mepc, "mepc_o");
    cause_check(mcause_o, m_mcause, "mcause_o");
    count_check(minstret_o, m_minstret, "minstret_o");
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] f;
    logic [31:0] g;
    logic [31:0] h;
    wb_instr_t   w;
    csr_wr_t     c;
    r = $random(seed);
    f = $random(seed);
    g = $random(seed);
    h = $random(seed);
    w         = '0;
    w.valid   = r[0] | r[1];
    w.pc      = {g[31:2], 2'b00};
    // Each fault flag shows up about once in 32 instructions
    w.mpu_err = (f[4:0] == 5'd0);
    w.bus_err = (f[9:5] == 5'd0);
    w.illegal = (f[14:10] == 5'd0);
    w.ecall   = (f[19:15] == 5'd0);
    w.ebrk    = (f[24:20] == 5'd0);
    w.mret    = (f[28:25] == 4'd0);
    c         = '0;
    c.en      = (r[9:6] == 4'd0);
    if (r[11:10] == 2'd0) begin
      c.sel = CSR_MIE;
    end else if (r[11:10] == 2'd1) begin
      c.sel = CSR_MEPC;
    end else begin
      c.sel = CSR_MSTATUS;
    end
    c.data         = h;
    wb_i           = w;
    csr_wr_i       = c;
    // Sparse lines show up in about a quarter of the cycles
    irq_i          = (r[4:3] == 2'b00) ? (g[15:0] & g[31:16] & h[15:0]) : '0;
    debug_step_i   = step_lvl;
    debug_resume_i = resume_req;
  endtask

  // The model steps at the edge and outputs are checked 1 ns later, before inputs change
  task automatic run_cycle();
    @(posedge clk);
    advance_model();
    #1;
    compare_all();
    #1;
    drive_inputs();
  endtask

  task automatic single_step();
    count_t base;
    int     n;
    step_lvl = 1'b1;
    run_cycle();
    base = minstret_o;
    n    = 0;
    while (!debug_mode_o) begin
      if (n == WAIT_TIMEOUT) begin
        abort_run("Timed out waiting for debug mode after a single step");
      end else begin
        run_cycle();
        n++;
      end
    end
    count_check(minstret_o, base + 1, "retirements in the step window");
    step_lvl = 1'b0;
    repeat (HALT_CYCLES) run_cycle();
    count_check(minstret_o, base + 1, "retirements while halted");
    bit_check(debug_mode_o, 1'b1, "debug_mode_o before resume");
    resume_req = 1'b1;
    run_cycle();
    resume_req = 1'b0;
    n = 0;
    while (stall_o) begin
      if (n == WAIT_TIMEOUT) begin
        abort_run("Timed out waiting for the core to leave debug mode after resume");
      end else begin
        run_cycle();
        n++;
      end
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    wb_i           = '0;
    irq_i          = '0;
    csr_wr_i       = '0;
    debug_step_i   = 1'b0;
    debug_resume_i = 1'b0;
    step_lvl       = 1'b0;
    resume_req     = 1'b0;
    reset_model();
    repeat (10) @(posedge clk);
    // Everything reads zero and RUN while still in reset
    #1;
    compare_all();
    #1;
    rst_ni = 1'b1;
    repeat (RAND_CYCLES) run_cycle();
    repeat (STEP_ROUNDS) single_step();
    repeat (RAND_CYCLES / 4) run_cycle();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/retire_counter.sv
`timescale 1ns/1ps
`default_nettype none

module retire_counter (
  input  logic                clk,
  input  logic                rst_ni,
  input  trap_pkg::trap_req_t req_i,
  input  logic                debug_step_i,
  output trap_pkg::count_t    minstret_o,
  output logic                step_done_o
);

  import trap_pkg::*;

  count_t minstret_q;
  logic   step_pend_q;
  logic   step_win;

  // Counts every retirement and never a trap
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      minstret_q <= '0;
    end else if (req_i.retire) begin
      minstret_q <= minstret_q + count_t'(1);
    end
  end

  //////////////////////////////
  // Step window
  //////////////////////////////

  // A trap taken while stepping keeps the step open into the handler
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      step_pend_q <= 1'b0;
    end else if (step_done_o) begin
      step_pend_q <= 1'b0;
    end else if (req_i.take && debug_step_i) begin
      step_pend_q <= 1'b1;
    end
  end

  assign step_win = debug_step_i | step_pend_q;

  // Only a real retirement closes the step
  assign step_done_o = req_i.retire & step_win;
  assign minstret_o  = minstret_q;

endmodule

`default_nettype wire

//--- src/trap_cause_sel.sv
`timescale 1ns/1ps
`default_nettype none

module trap_cause_sel (
  input  trap_pkg::wb_instr_t wb_i,
  input  trap_pkg::irq_vec_t  irq_i,
  input  trap_pkg::irq_vec_t  mie_i,
  input  logic                mstatus_mie_i,
  input  logic                accept_i,
  output trap_pkg::trap_req_t req_o
);

  import trap_pkg::*;

  irq_vec_t  irq_en;
  logic      irq_hit;
  exc_code_t irq_idx;
  logic      exc_hit;
  exc_code_t exc_code;
  logic      fire;

  // Only a valid instruction seen while the controller is running is decided on
  assign fire = wb_i.valid & accept_i;

  // Pending lines that are also enabled in mie
  assign irq_en  = irq_i & mie_i;
  // The global enable in mstatus gates all of them at once
  assign irq_hit = mstatus_mie_i & (|irq_en);

  // Scan from the top down so the lowest set index is the one left standing
  always_comb begin : irq_prio
    irq_idx = '0;
    for (int i = 15; i >= 0; i--) begin
      if (irq_en[i]) begin
        irq_idx = exc_code_t'(i);
      end
    end
  end

  // Fetch faults first, then decode faults, then the system instructions
  always_comb begin : exc_prio
    exc_hit  = 1'b1;
    exc_code = EXC_INSTR_FAULT;
    if (wb_i.mpu_err) begin
      exc_code = EXC_INSTR_FAULT;
    end else if (wb_i.bus_err) begin
      exc_code = EXC_INSTR_BUS_FAULT;
    end else if (wb_i.illegal) begin
      exc_code = EXC_ILLEGAL_INSN;
    end else if (wb_i.ecall) begin
      exc_code = EXC_ECALL_MMODE;
    end else if (wb_i.ebrk) begin
      exc_code = EXC_BREAKPOINT;
    end else begin
      exc_hit = 1'b0;
    end
  end

  //////////////////////////////
  // Request
  //////////////////////////////

  always_comb begin : build_req
    req_o = '0;
    if (fire) begin
      // Both trap kinds keep the PC of the instruction that did not retire
      req_o.epc = wb_i.pc;
      if (irq_hit) begin
        req_o.take                 = 1'b1;
        req_o.cause.interrupt      = 1'b1;
        req_o.cause.exception_code = irq_idx;
      end else if (exc_hit) begin
        req_o.take                 = 1'b1;
        req_o.cause.exception_code = exc_code;
      end else begin
        // A clean instruction retires, and MRET is one of those
        req_o.retire = 1'b1;
        req_o.mret   = wb_i.mret;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/trap_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csr_regs (
  input  logic                clk,
  input  logic                rst_ni,
  input  trap_pkg::trap_req_t req_i,
  input  trap_pkg::csr_wr_t   csr_wr_i,
  output trap_pkg::irq_vec_t  mie_o,
  output logic                mstatus_mie_o,
  output trap_pkg::addr_t     mepc_o,
  output trap_pkg::mcause_t   mcause_o
);

  import trap_pkg::*;

  irq_vec_t mie_q;
  logic     mstatus_mie_q;
  logic     mstatus_mpie_q;
  addr_t    mepc_q;
  mcause_t  mcause_q;

  logic     wr_mie;
  logic     wr_mstatus;
  logic     wr_mepc;

  // Decode of the software write port
  assign wr_mie     = csr_wr_i.en && (csr_wr_i.sel == CSR_MIE);
  assign wr_mstatus = csr_wr_i.en && (csr_wr_i.sel == CSR_MSTATUS);
  assign wr_mepc    = csr_wr_i.en && (csr_wr_i.sel == CSR_MEPC);

  //////////////////////////////
  // Interrupt enable
  //////////////////////////////

  // Traps never touch mie, so a write here always lands
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (wr_mie) begin
      mie_q <= csr_wr_i.data[15:0];
    end
  end

  //////////////////////////////
  // mstatus
  //////////////////////////////

  // Trap entry stacks the global enable, MRET unstacks it
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (req_i.take) begin
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (req_i.mret) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (wr_mstatus) begin
      // Bit 3 is the global interrupt enable
      mstatus_mie_q <= csr_wr_i.data[3];
    end
  end

  //////////////////////////////
  // Trap state
  //////////////////////////////

  // The trap wins over a software write in the same cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mepc_q <= '0;
    end else if (req_i.take) begin
      mepc_q <= req_i.epc;
    end else if (wr_mepc) begin
      mepc_q <= csr_wr_i.data;
    end
  end

  // Only hardware writes mcause
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mcause_q <= '0;
    end else if (req_i.take) begin
      mcause_q <= req_i.cause;
    end
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mepc_o        = mepc_q;
  assign mcause_o      = mcause_q;

endmodule

`default_nettype wire

//--- src/trap_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl_fsm #(
  parameter trap_pkg::addr_t MTVEC_BASE = 32'h0000_0100
) (
  input  logic                clk,
  input  logic                rst_ni,
  input  trap_pkg::trap_req_t req_i,
  input  logic                step_done_i,
  input  logic                debug_resume_i,
  input  trap_pkg::addr_t     mepc_i,
  output logic                accept_o,
  output logic                trap_o,
  output logic                mret_o,
  output trap_pkg::addr_t     redirect_pc_o,
  output logic                stall_o,
  output logic                debug_mode_o
);

  import trap_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        mret_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      ST_RUN: begin
        // A trap and a step retirement cannot both happen in one slot
        if (req_i.take) begin
          state_d = ST_TRAP;
        end else if (step_done_i) begin
          state_d = ST_HALT;
        end
      end
      ST_TRAP: begin
        // One cycle for the redirect to the vector, then the handler runs
        state_d = ST_RUN;
      end
      ST_HALT: begin
        if (debug_resume_i) begin
          state_d = ST_RUN;
        end
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // MRET is reported the cycle after it retires, also when a step halt follows
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mret_q <= 1'b0;
    end else begin
      mret_q <= req_i.mret;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Writeback is only consumed while running
  assign accept_o     = (state_q == ST_RUN);
  assign trap_o       = (state_q == ST_TRAP);
  assign stall_o      = (state_q != ST_RUN);
  assign debug_mode_o = (state_q == ST_HALT);
  assign mret_o       = mret_q;

  // Vector on trap entry, otherwise the return address held in mepc
  assign redirect_pc_o = trap_o ? MTVEC_BASE : mepc_i;

endmodule

`default_nettype wire

//--- src/trap_pkg.sv
`default_nettype none

package trap_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // PC values and CSR write data share this width
  typedef logic [31:0] addr_t;
  // One bit per interrupt line in the same layout as the mie CSR
  typedef logic [15:0] irq_vec_t;
  typedef logic [4:0]  exc_code_t;
  typedef logic [31:0] count_t;

  // Synchronous exception codes as reported in mcause
  localparam exc_code_t EXC_INSTR_FAULT     = 5'd1;
  localparam exc_code_t EXC_ILLEGAL_INSN    = 5'd2;
  localparam exc_code_t EXC_BREAKPOINT      = 5'd3;
  localparam exc_code_t EXC_ECALL_MMODE     = 5'd11;
  localparam exc_code_t EXC_INSTR_BUS_FAULT = 5'd24;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  typedef struct packed {
    logic      interrupt;
    exc_code_t exception_code;
  } mcause_t;

  // The instruction at writeback with its fault and system flags
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  mpu_err;
    logic  bus_err;
    logic  illegal;
    logic  ecall;
    logic  ebrk;
    logic  mret;
  } wb_instr_t;

  typedef enum logic [1:0] {
    CSR_MIE,
    CSR_MSTATUS,
    CSR_MEPC
  } csr_sel_e;

  typedef struct packed {
    logic     en;
    csr_sel_e sel;
    addr_t    data;
  } csr_wr_t;

  // Decision for the current writeback slot that the CSRs, counter and FSM all read
  typedef struct packed {
    logic    take;
    mcause_t cause;
    addr_t   epc;
    logic    retire;
    logic    mret;
  } trap_req_t;

  typedef enum logic [1:0] {
    ST_RUN,
    ST_TRAP,
    ST_HALT
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module trap_unit #(
  parameter trap_pkg::addr_t MTVEC_BASE = 32'h0000_0100
) (
  input  logic                clk,
  input  logic                rst_ni,
  input  trap_pkg::wb_instr_t wb_i,
  input  trap_pkg::irq_vec_t  irq_i,
  input  trap_pkg::csr_wr_t   csr_wr_i,
  input  logic                debug_step_i,
  input  logic                debug_resume_i,
  output logic                trap_o,
  output logic                mret_o,
  output trap_pkg::addr_t     redirect_pc_o,
  output logic                stall_o,
  output logic                debug_mode_o,
  output trap_pkg::addr_t     mepc_o,
  output trap_pkg::mcause_t   mcause_o,
  output logic                mstatus_mie_o,
  output trap_pkg::count_t    minstret_o
);

  import trap_pkg::*;

  trap_req_t req;
  irq_vec_t  mie;
  logic      accept;
  logic      step_done;

  //////////////////////////////
  // Decision
  //////////////////////////////

  // Reads the live CSR state, so an enable change takes effect the next cycle
  trap_cause_sel u_cause_sel (
    .wb_i          (wb_i),
    .irq_i         (irq_i),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie_o),
    .accept_i      (accept),
    .req_o         (req)
  );

  //////////////////////////////
  // State
  //////////////////////////////

  trap_csr_regs u_csr_regs (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .req_i         (req),
    .csr_wr_i      (csr_wr_i),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie_o),
    .mepc_o        (mepc_o),
    .mcause_o      (mcause_o)
  );

  retire_counter u_retire_counter (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_i        (req),
    .debug_step_i (debug_step_i),
    .minstret_o   (minstret_o),
    .step_done_o  (step_done)
  );

  // Controller closes the loop through accept
  trap_ctrl_fsm #(
    .MTVEC_BASE (MTVEC_BASE)
  ) u_ctrl_fsm (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .req_i          (req),
    .step_done_i    (step_done),
    .debug_resume_i (debug_resume_i),
    .mepc_i         (mepc_o),
    .accept_o       (accept),
    .trap_o         (trap_o),
    .mret_o         (mret_o),
    .redirect_pc_o  (redirect_pc_o),
    .stall_o        (stall_o),
    .debug_mode_o   (debug_mode_o)
  );

endmodule

`default_nettype wire
